/* tests/dma_read_tests.dat */
# name mode len0 len1 late0 addr0 addr1 words0 words1 (lengths and words decimal, addresses hex)
# mode: 0 write+run, 1 write+clear+run, 2 run only, 3 write+run+late write of late0 to port 0
single_short 0 9 0 0 00001000 00002000 30 0
long_block 0 600 0 0 00010000 00020000 1202 0
both_ports 0 20 6 0 00003000 00004000 42 14
cleared 1 50 70 0 00005000 0000fff8 5 3
late_write 3 4 2 100 00006000 00007000 15 6
rerun 2 0 0 0 00008000 00009000 202 0
long_port1 0 1 300 0 00020000 00030000 4 602

/* all.f */
verilog/dma_pkg.sv
verilog/dma_config.sv
verilog/read_merge.sv
verilog/axi_read_master.sv
verilog/dma_read_top.sv
tests/axi_mem_slave.sv
tests/dma_read_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/10ps -f all.f --top-module dma_read_tb -o dma_read_sim
	./obj_dir/dma_read_sim > sim.log 2>&1; cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/dma_read_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module dma_read_tb;
	import dma_pkg::*;

	localparam int N_PORTS = 2;
	localparam int MAX_TESTS = 16;

	logic clk;
	logic rst;
	logic clear;
	logic run;
	logic cfg_valid;
	cfg_addr_t cfg_addr;
	cnt_t cfg_wdata;
	logic [N_PORTS-1:0] rd_valid;
	addr_t [N_PORTS-1:0] rd_addr;
	wire [N_PORTS-1:0] rd_ready;
	wire data_t rd_rdata;
	wire addr_t araddr;
	wire axi_len_t arlen;
	wire arvalid;
	wire arready;
	wire data_t rdata;
	wire rlast;
	wire rvalid;
	wire rready;

	// vectors from the data file
	logic [127:0] t_name [MAX_TESTS];
	int t_mode [MAX_TESTS];
	cnt_t t_len [MAX_TESTS][N_PORTS];
	cnt_t t_late [MAX_TESTS];
	addr_t t_addr [MAX_TESTS][N_PORTS];
	int t_words [MAX_TESTS][N_PORTS];
	int n_tests;
	int cycle_limit;

	// reference model of the length registers and port state
	cnt_t reg_m [N_PORTS];
	cnt_t shadow_m [N_PORTS];
	cnt_t cnt_m [N_PORTS];
	addr_t port_addr [N_PORTS];
	int left [N_PORTS];
	int cur_port;
	string cur_name;
	logic in_burst;
	logic beat_q;
	int err_word;
	int err_len;
	int err_addr;
	int err_flag;
	int err_other;

	dma_read_top #(
		.N_PORTS(N_PORTS)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.clear(clear),
		.run(run),
		.cfg_valid(cfg_valid),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.rd_valid(rd_valid),
		.rd_addr(rd_addr),
		.rd_ready(rd_ready),
		.rd_rdata(rd_rdata),
		.m_axi_araddr(araddr),
		.m_axi_arlen(arlen),
		.m_axi_arvalid(arvalid),
		.m_axi_arready(arready),
		.m_axi_rdata(rdata),
		.m_axi_rlast(rlast),
		.m_axi_rvalid(rvalid),
		.m_axi_rready(rready)
	);

	axi_mem_slave mem_i (
		.clk(clk),
		.rst(rst),
		.araddr(araddr),
		.arlen(arlen),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_word(input string name, input data_t exp, input data_t act);
		if (exp !== act) begin
			$display("Error %s rd_rdata: expected %h, actual %h", name, exp, act);
			err_word++;
		end
	endtask

	task automatic check_len(input string name, input axi_len_t exp, input axi_len_t act);
		if (exp !== act) begin
			$display("Error %s arlen: expected %0d, actual %0d", name, exp, act);
			err_len++;
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (exp !== act) begin
			$display("Error %s araddr: expected %h, actual %h", name, exp, act);
			err_addr++;
		end
	endtask

	task automatic check_flag(input string name, input string sig, input logic exp,
		input logic act);
		if (exp !== act) begin
			$display("Error %s %s: expected %b, actual %b", name, sig, exp, act);
			err_flag++;
		end
	endtask

	task automatic load_vectors();
		int fd;
		int got;
		string line;
		logic [127:0] name;
		int mode;
		int len0;
		int len1;
		int late;
		int words0;
		int words1;
		logic [31:0] addr0;
		logic [31:0] addr1;
		n_tests = 0;
		fd = $fopen("tests/dma_read_tests.dat", "r");
		if (fd == 0) begin
			$display("could not open tests/dma_read_tests.dat");
			err_other++;
			return;
		end
		while (!$feof(fd) && n_tests < MAX_TESTS) begin
			line = "";
			got = $fgets(line, fd);
			if (got > 0 && line.len() > 1 && line[0] != "#") begin
				got = $sscanf(line, "%s %d %d %d %d %h %h %d %d", name, mode, len0, len1,
					late, addr0, addr1, words0, words1);
				if (got == 9) begin
					t_name[n_tests] = name;
					t_mode[n_tests] = mode;
					t_len[n_tests][0] = cnt_t'(len0);
					t_len[n_tests][1] = cnt_t'(len1);
					t_late[n_tests] = cnt_t'(late);
					t_addr[n_tests][0] = addr0;
					t_addr[n_tests][1] = addr1;
					t_words[n_tests][0] = words0;
					t_words[n_tests][1] = words1;
					n_tests++;
				end
			end
		end
		$fclose(fd);
	endtask

	// one clock of model update and checks on the pre-edge values
	task automatic tick();
		int p;
		axi_len_t exp_len;
		@(posedge clk);
		for (int i = 0; i < N_PORTS; i++) begin
			if (run) begin
				shadow_m[i] = reg_m[i];
				cnt_m[i] = reg_m[i];
			end
			if (clear) begin
				reg_m[i] = '0;
			end else if (cfg_valid && cfg_addr == cfg_addr_t'(i)) begin
				reg_m[i] = cfg_wdata;
			end
		end
		// rready spans AR accept up to the last beat
		check_flag(cur_name, "rready", in_burst, rready);
		// each word trails its R beat by one cycle
		check_flag(cur_name, "rd_ready", beat_q, |rd_ready);
		if (rvalid && rready && rlast) begin
			in_burst = 1'b0;
		end
		if (arvalid && arready) begin
			in_burst = 1'b1;
		end
		beat_q = rvalid && rready;
		if (arvalid && arready) begin
			p = -1;
			for (int i = N_PORTS - 1; i >= 0; i--) begin
				if (left[i] > 0) begin
					p = i;
				end
			end
			if (p < 0) begin
				$display("burst requested in %s while no port was waiting", cur_name);
				err_other++;
			end else begin
				if (cnt_m[p] > 16'd255) begin
					exp_len = 8'd255;
				end else begin
					exp_len = cnt_m[p][7:0];
				end
				check_addr(cur_name, port_addr[p], araddr);
				check_len(cur_name, exp_len, arlen);
				cur_port = p;
			end
		end
		if (rd_ready != '0 && rd_ready != (N_PORTS'(1) << cur_port)) begin
			$display("in %s words went to ports %b during a burst for port %0d", cur_name,
				rd_ready, cur_port);
			err_other++;
		end
		for (int i = 0; i < N_PORTS; i++) begin
			if (rd_ready[i]) begin
				if (left[i] == 0) begin
					$display("port %0d got a word it did not ask for in %s", i, cur_name);
					err_other++;
				end else begin
					check_word(cur_name, {port_addr[i][15:0], ~port_addr[i][15:0]}, rd_rdata);
					port_addr[i] = port_addr[i] + 32'd4;
					left[i]--;
					rd_addr[i] <= port_addr[i];
					if (left[i] == 0) begin
						rd_valid[i] <= 1'b0;
					end
				end
				// block wraps at zero
				if (cnt_m[i] == '0) begin
					cnt_m[i] = shadow_m[i];
				end else begin
					cnt_m[i] = cnt_m[i] - 16'd1;
				end
			end
		end
	endtask

	task automatic write_len(input cfg_addr_t a, input cnt_t v);
		tick();
		cfg_valid <= 1'b1;
		cfg_addr <= a;
		cfg_wdata <= v;
		tick();
		cfg_valid <= 1'b0;
	endtask

	// mode 0 write and run, 1 adds a clear, 2 run only, 3 adds a write after run
	task automatic run_test(input int t);
		int busy_ports;
		cur_name = $sformatf("%0s", t_name[t]);
		if (t_mode[t] != 2) begin
			for (int i = 0; i < N_PORTS; i++) begin
				write_len(cfg_addr_t'(i), t_len[t][i]);
			end
			// no such port
			write_len(cfg_addr_t'(N_PORTS + 1), 16'hffff);
		end
		if (t_mode[t] == 1) begin
			tick();
			clear <= 1'b1;
			tick();
			clear <= 1'b0;
		end
		tick();
		run <= 1'b1;
		tick();
		run <= 1'b0;
		for (int i = 0; i < N_PORTS; i++) begin
			port_addr[i] = t_addr[t][i];
			left[i] = t_words[t][i];
			rd_addr[i] <= t_addr[t][i];
			rd_valid[i] <= (t_words[t][i] > 0);
		end
		if (t_mode[t] == 3) begin
			write_len(cfg_addr_t'(0), t_late[t]);
		end
		busy_ports = 1;
		while (busy_ports > 0) begin
			tick();
			busy_ports = 0;
			for (int i = 0; i < N_PORTS; i++) begin
				busy_ports += left[i];
			end
		end
		repeat (3) tick();
	endtask

	task automatic print_counts();
		$display("errors: %0d rd_rdata, %0d arlen, %0d araddr, %0d handshake, %0d other",
			err_word, err_len, err_addr, err_flag, err_other);
	endtask

	initial begin
		cycle_limit = 0;
		wait (cycle_limit > 0);
		repeat (cycle_limit) @(posedge clk);
		$display("transfers did not finish within %0d cycles", cycle_limit);
		print_counts();
		$display("Checks failed");
		$finish;
	end

	initial begin
		int total;
		rst = 1'b1;
		clear = 1'b0;
		run = 1'b0;
		cfg_valid = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		rd_valid = '0;
		rd_addr = '0;
		err_word = 0;
		err_len = 0;
		err_addr = 0;
		err_flag = 0;
		err_other = 0;
		cur_port = 0;
		cur_name = "reset";
		in_burst = 1'b0;
		beat_q = 1'b0;
		for (int i = 0; i < N_PORTS; i++) begin
			reg_m[i] = '0;
			shadow_m[i] = '0;
			cnt_m[i] = '0;
			port_addr[i] = '0;
			left[i] = 0;
		end
		load_vectors();
		if (n_tests == 0) begin
			$display("no test vectors were read");
			err_other++;
		end
		total = 0;
		for (int t = 0; t < n_tests; t++) begin
			total += t_words[t][0] + t_words[t][1];
		end
		cycle_limit = 64 * total + 200;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		for (int t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		print_counts();
		if (err_word + err_len + err_addr + err_flag + err_other == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tests/axi_mem_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_mem_slave (
	input wire clk,
	input wire rst,
	input wire dma_pkg::addr_t araddr,
	input wire dma_pkg::axi_len_t arlen,
	input wire arvalid,
	output logic arready,
	output dma_pkg::data_t rdata,
	output logic rlast,
	output logic rvalid,
	input wire rready
);
	import dma_pkg::*;

	localparam logic [31:0] SEED = 32'hd2b399ff;

	logic [31:0] lfsr;
	logic busy;
	addr_t beat_addr;
	axi_len_t left;

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// memory contents follow the address
	function automatic data_t word_at(input addr_t a);
		return {a[15:0], ~a[15:0]};
	endfunction

	always_ff @(posedge clk or posedge rst) begin
		logic [31:0] nxt;
		addr_t next_addr;
		axi_len_t next_left;
		if (rst) begin
			lfsr <= SEED;
			arready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			rdata <= '0;
			busy <= 1'b0;
			beat_addr <= '0;
			left <= '0;
		end else if (!busy) begin
			if (arvalid && arready) begin
				busy <= 1'b1;
				beat_addr <= araddr;
				left <= arlen;
				arready <= 1'b0;
			end else begin
				nxt = lfsr_next(lfsr);
				lfsr <= nxt;
				arready <= nxt[0];
			end
		end else if (rvalid && rready && rlast) begin
			busy <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
		end else if (!rvalid || rready) begin
			// slot is free, maybe present the next beat
			nxt = lfsr_next(lfsr);
			next_addr = beat_addr;
			next_left = left;
			if (rvalid) begin
				next_addr = beat_addr + 32'd4;
				next_left = left - 1'b1;
			end
			lfsr <= nxt;
			beat_addr <= next_addr;
			left <= next_left;
			rvalid <= nxt[0];
			rdata <= word_at(next_addr);
			rlast <= (next_left == '0);
		end
	end

endmodule

`default_nettype wire

/* verilog/dma_read_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dma_read_top #(
	parameter int N_PORTS = 2
) (
	input wire clk,
	input wire rst,

	// host
	input wire clear,
	input wire run,
	input wire cfg_valid,
	input wire dma_pkg::cfg_addr_t cfg_addr,
	input wire dma_pkg::cnt_t cfg_wdata,

	// read ports
	input wire [N_PORTS-1:0] rd_valid,
	input wire dma_pkg::addr_t [N_PORTS-1:0] rd_addr,
	output wire [N_PORTS-1:0] rd_ready,
	output wire dma_pkg::data_t rd_rdata,

	// AXI read master
	output wire dma_pkg::addr_t m_axi_araddr,
	output wire dma_pkg::axi_len_t m_axi_arlen,
	output wire m_axi_arvalid,
	input wire m_axi_arready,
	input wire dma_pkg::data_t m_axi_rdata,
	input wire m_axi_rlast,
	input wire m_axi_rvalid,
	output wire m_axi_rready
);
	import dma_pkg::*;

	wire axi_len_t [N_PORTS-1:0] burst_len;
	wire req_valid;
	wire addr_t req_addr;
	wire axi_len_t req_len;
	wire [1:0] req_port;
	wire req_take;
	wire burst_done;

	dma_config #(
		.N_PORTS(N_PORTS)
	) config_i (
		.clk(clk),
		.rst(rst),
		.clear(clear),
		.run(run),
		.cfg_valid(cfg_valid),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.rd_ready(rd_ready),
		.burst_len(burst_len)
	);

	read_merge #(
		.N_PORTS(N_PORTS)
	) merge_i (
		.clk(clk),
		.rst(rst),
		.rd_valid(rd_valid),
		.rd_addr(rd_addr),
		.burst_len(burst_len),
		.req_take(req_take),
		.burst_done(burst_done),
		.req_valid(req_valid),
		.req_addr(req_addr),
		.req_len(req_len),
		.req_port(req_port)
	);

	axi_read_master #(
		.N_PORTS(N_PORTS)
	) master_i (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_addr(req_addr),
		.req_len(req_len),
		.req_port(req_port),
		.req_take(req_take),
		.burst_done(burst_done),
		.rd_ready(rd_ready),
		.rd_rdata(rd_rdata),
		.m_axi_araddr(m_axi_araddr),
		.m_axi_arlen(m_axi_arlen),
		.m_axi_arvalid(m_axi_arvalid),
		.m_axi_arready(m_axi_arready),
		.m_axi_rdata(m_axi_rdata),
		.m_axi_rlast(m_axi_rlast),
		.m_axi_rvalid(m_axi_rvalid),
		.m_axi_rready(m_axi_rready)
	);

endmodule

`default_nettype wire

/* verilog/axi_read_master.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_read_master #(
	parameter int N_PORTS = 2
) (
	input wire clk,
	input wire rst,

	// request from the merge
	input wire req_valid,
	input wire dma_pkg::addr_t req_addr,
	input wire dma_pkg::axi_len_t req_len,
	input wire [1:0] req_port,
	output logic req_take,
	output logic burst_done,

	// word return to the ports
	output logic [N_PORTS-1:0] rd_ready,
	output dma_pkg::data_t rd_rdata,

	// AR channel
	output dma_pkg::addr_t m_axi_araddr,
	output dma_pkg::axi_len_t m_axi_arlen,
	output logic m_axi_arvalid,
	input wire m_axi_arready,

	// R channel
	input wire dma_pkg::data_t m_axi_rdata,
	input wire m_axi_rlast,
	input wire m_axi_rvalid,
	output logic m_axi_rready
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ADDR,
		S_DATA
	} state_t;

	state_t state;
	logic [1:0] port_q;
	logic beat;

	// accept a request only between bursts
	assign req_take = (state == S_IDLE) && req_valid;

	assign m_axi_arvalid = (state == S_ADDR);
	assign m_axi_rready = (state == S_DATA);
	assign beat = m_axi_rvalid && m_axi_rready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (req_valid) begin
						state <= S_ADDR;
					end
				end
				S_ADDR: begin
					// rready rises on the same edge
					if (m_axi_arready) begin
						state <= S_DATA;
					end
				end
				S_DATA: begin
					if (beat && m_axi_rlast) begin
						state <= S_IDLE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// AR fields stay put until arready
	always_ff @(posedge clk) begin
		if (req_take) begin
			m_axi_araddr <= req_addr;
			m_axi_arlen <= req_len;
			port_q <= req_port;
		end
		if (beat) begin
			rd_rdata <= m_axi_rdata;
		end
	end

	// one strobe per beat to the granted port only
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ready <= '0;
			burst_done <= 1'b0;
		end else begin
			for (int i = 0; i < N_PORTS; i++) begin
				rd_ready[i] <= beat && (port_q == 2'(i));
			end
			burst_done <= beat && m_axi_rlast;
		end
	end

endmodule

`default_nettype wire

/* verilog/read_merge.sv */
`timescale 1ns/10ps
`default_nettype none

module read_merge #(
	parameter int N_PORTS = 2
) (
	input wire clk,
	input wire rst,
	input wire [N_PORTS-1:0] rd_valid,
	input wire dma_pkg::addr_t [N_PORTS-1:0] rd_addr,
	input wire dma_pkg::axi_len_t [N_PORTS-1:0] burst_len,
	input wire req_take,
	input wire burst_done,
	output logic req_valid,
	output dma_pkg::addr_t req_addr,
	output dma_pkg::axi_len_t req_len,
	output logic [1:0] req_port
);

	logic busy;
	logic [1:0] grant_q;
	logic [1:0] pick;

	// lowest index wins, so scan downwards
	always_comb begin
		pick = '0;
		for (int i = N_PORTS - 1; i >= 0; i--) begin
			if (rd_valid[i]) begin
				pick = 2'(i);
			end
		end
	end

	assign req_valid = (|rd_valid) && !busy;

	// frozen while a burst is in flight
	assign req_port = busy ? grant_q : pick;

	always_comb begin
		req_addr = rd_addr[0];
		req_len = burst_len[0];
		for (int i = 1; i < N_PORTS; i++) begin
			if (req_port == 2'(i)) begin
				req_addr = rd_addr[i];
				req_len = burst_len[i];
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			grant_q <= '0;
		end else if (req_take) begin
			busy <= 1'b1;
			grant_q <= pick;
		end else if (burst_done) begin
			busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* verilog/dma_config.sv */
`timescale 1ns/10ps
`default_nettype none

module dma_config #(
	parameter int N_PORTS = 2
) (
	input wire clk,
	input wire rst,
	input wire clear,
	input wire run,
	input wire cfg_valid,
	input wire dma_pkg::cfg_addr_t cfg_addr,
	input wire dma_pkg::cnt_t cfg_wdata,
	input wire [N_PORTS-1:0] rd_ready,
	output wire dma_pkg::axi_len_t [N_PORTS-1:0] burst_len
);
	import dma_pkg::*;

	genvar i;
	generate
		for (i = 0; i < N_PORTS; i++) begin : g_port
			cnt_t len_q;
			cnt_t len_shadow;
			cnt_t cnt;
			logic wr_en;

			// addresses past the last port never match
			assign wr_en = cfg_valid && (cfg_addr == CFG_LEN_BASE + cfg_addr_t'(i));

			// host register, clear wins over a write in the same cycle
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					len_q <= '0;
				end else if (clear) begin
					len_q <= '0;
				end else if (wr_en) begin
					len_q <= cfg_wdata;
				end
			end

			// shadow only follows the register on run
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					len_shadow <= '0;
				end else if (run) begin
					len_shadow <= len_q;
				end
			end

			// words left in the current block, minus one
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					cnt <= '0;
				end else if (run) begin
					cnt <= len_q;
				end else if (rd_ready[i]) begin
					if (cnt == '0) begin
						// block finished, start the next one
						cnt <= len_shadow;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
			end

			// cap to 256 beats
			assign burst_len[i] = (cnt[CNT_W-1:LEN_W] != '0) ? MAX_BURST : cnt[LEN_W-1:0];
		end
	endgenerate

endmodule

`default_nettype wire

/* verilog/dma_pkg.sv */
`default_nettype none

package dma_pkg;

	// bus and counter widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int LEN_W = 8;
	localparam int CNT_W = 16;
	localparam int CFG_ADDR_W = 4;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [LEN_W-1:0] axi_len_t;
	typedef logic [CNT_W-1:0] cnt_t;
	typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;

	// length register of port i sits at CFG_LEN_BASE + i
	localparam cfg_addr_t CFG_LEN_BASE = '0;

	// longest AXI4 incr burst, as an arlen value
	localparam axi_len_t MAX_BURST = '1;

endpackage

`default_nettype wire
